// File: bgpu_mem_stim.txt
# op port addr wdata be expected, all hex except port; op W write, R read, S wait for idle
# port 0 uses byte addresses and 32-bit results, port 1 uses line indices and 128-bit results
R 0 040 00000000 0 00000000
R 1 03 00000000 0 00000000000000000000000000000000
S 0 0 0 0 0
W 0 010 deadbeef f 00000000
R 0 010 00000000 0 deadbeef
S 0 0 0 0 0
W 0 020 11223344 f 00000000
W 0 020 aabbccdd 5 00000000
R 0 020 00000000 0 11bb33dd
S 0 0 0 0 0
W 0 050 a0000000 f 00000000
W 0 054 b1111111 f 00000000
W 0 058 c2222222 f 00000000
W 0 05c d3333333 f 00000000
S 0 0 0 0 0
R 1 05 00000000 0 d3333333c2222222b1111111a0000000
S 0 0 0 0 0
W 0 080 cafe0001 f 00000000
R 1 05 00000000 0 d3333333c2222222b1111111a0000000
R 0 080 00000000 0 cafe0001
R 1 01 00000000 0 000000000000000000000000deadbeef
W 0 084 cafe0002 3 00000000
R 1 02 00000000 0 0000000000000000000000000011bb33dd
R 0 084 00000000 0 00000002
R 1 05 00000000 0 d3333333c2222222b1111111a0000000
R 1 03 00000000 0 00000000000000000000000000000000
R 1 01 00000000 0 000000000000000000000000deadbeef
S 0 0 0 0 0

// File: filelist.f
bgpu_mem_pkg.sv
ctrl_dw_conv.sv
mctrl_mux.sv
mem_spill_reg.sv
mctrl_mem.sv
bgpu_mem_top.sv
tb_clk_gen.sv
tb_bgpu_mem_assert.sv
tb_bgpu_mem.sv

// File: Makefile
# Verilator simulation of the memory path testbench

VERILATOR ?= verilator
TOP       ?= tb_bgpu_mem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_bgpu_mem.sv
// ##################################################
// Runs bgpu_mem_stim.txt in phases and each S line waits for idle
// Run from the project root so the stimulus file is found
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module tb_bgpu_mem;
    logic                      clk_i, arst_n_i;
    logic                      ctrl_req_valid_i, ctrl_req_ready_o, ctrl_we_i;
    bgpu_mem_pkg::ctrl_addr_t  ctrl_addr_i;
    bgpu_mem_pkg::ctrl_data_t  ctrl_wdata_i, ctrl_rdata_o;
    bgpu_mem_pkg::ctrl_be_t    ctrl_be_i;
    logic                      ctrl_rsp_valid_o, ctrl_rsp_ready_i;
    logic                      imem_req_valid_i, imem_req_ready_o;
    bgpu_mem_pkg::line_addr_t  imem_addr_i;
    logic                      imem_rsp_valid_o, imem_rsp_ready_i;
    bgpu_mem_pkg::mctrl_data_t imem_rdata_o;

    int seed = 54388;
    int wait_limit = 200;
    int errors = 0;
    bit aborted = 1'b0;

    // Stimulus table with one entry per operation line
    logic [7:0]   st_op [$];
    int           st_port [$];
    logic [9:0]   st_addr [$];
    logic [31:0]  st_wdata [$];
    logic [3:0]   st_be [$];
    logic [127:0] st_exp [$];
    int           st_line [$];

    // Indices of the current phase
    int ctrl_req_q [$];
    int ctrl_rsp_q [$];
    int imem_req_q [$];
    int imem_rsp_q [$];

    tb_clk_gen i_clk_gen (.clk_o(clk_i), .arst_n_o(arst_n_i));

    bgpu_mem_top DUT (.*);

    // Random stalls on the instruction response
    always @(posedge clk_i) begin
        imem_rsp_ready_i <= (($random(seed) & 3) != 0);
    end

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic load_stim();
        int fd, rc, ln, port;
        string line;
        logic [7:0] op;
        logic [9:0] addr;
        logic [31:0] wdata;
        logic [3:0] be;
        logic [127:0] expv;
        fd = $fopen("bgpu_mem_stim.txt", "r");
        ln = 0;
        if (fd == 0) begin
            $display("Cannot open the stimulus file bgpu_mem_stim.txt");
            errors++;
            aborted = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                ln++;
                if (rc > 1 && line.getc(0) != 8'h23) begin
                    rc = $sscanf(line, "%c %d %h %h %h %h", op, port, addr, wdata, be, expv);
                    if (rc == 6) begin
                        st_op.push_back(op);
                        st_port.push_back(port);
                        st_addr.push_back(addr);
                        st_wdata.push_back(wdata);
                        st_be.push_back(be);
                        st_exp.push_back(expv);
                        st_line.push_back(ln);
                    end else begin
                        $display("Stimulus line %0d cannot be parsed", ln);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (st_op.size() == 0) begin
                $display("The stimulus file holds no operations");
                errors++;
            end
        end
    endtask

    task automatic drive_ctrl();
        int idx, cnt;
        while (ctrl_req_q.size() > 0 && !aborted) begin
            idx = ctrl_req_q.pop_front();
            @(posedge clk_i);
            ctrl_req_valid_i <= 1'b1;
            ctrl_we_i        <= (st_op[idx] == "W");
            ctrl_addr_i      <= st_addr[idx];
            ctrl_wdata_i     <= st_wdata[idx];
            ctrl_be_i        <= st_be[idx];
            cnt = 0;
            do begin
                @(negedge clk_i);
                cnt++;
            end while (!ctrl_req_ready_o && cnt < wait_limit && !aborted);
            if (!ctrl_req_ready_o && !aborted) begin
                report_timeout("control request ready");
            end
            @(posedge clk_i);
            ctrl_req_valid_i <= 1'b0;
        end
    endtask

    task automatic drive_imem();
        int idx, cnt;
        while (imem_req_q.size() > 0 && !aborted) begin
            idx = imem_req_q.pop_front();
            @(posedge clk_i);
            imem_req_valid_i <= 1'b1;
            imem_addr_i      <= st_addr[idx][5:0];
            cnt = 0;
            do begin
                @(negedge clk_i);
                cnt++;
            end while (!imem_req_ready_o && cnt < wait_limit && !aborted);
            if (!imem_req_ready_o && !aborted) begin
                report_timeout("instruction request ready");
            end
            @(posedge clk_i);
            imem_req_valid_i <= 1'b0;
        end
    endtask

    task automatic check_ctrl();
        int idx, cnt;
        while (ctrl_rsp_q.size() > 0 && !aborted) begin
            idx = ctrl_rsp_q.pop_front();
            cnt = 0;
            do begin
                @(negedge clk_i);
                cnt++;
            end while (!ctrl_rsp_valid_o && cnt < wait_limit && !aborted);
            if (!ctrl_rsp_valid_o) begin
                if (!aborted) begin
                    report_timeout("control response");
                end
            end else if (st_op[idx] == "R" && ctrl_rdata_o !== st_exp[idx][31:0]) begin
                $display("[FAIL] ctrl read, stim line %0d: expected %h, actual %h",
                         st_line[idx], st_exp[idx][31:0], ctrl_rdata_o);
                errors++;
            end
        end
    endtask

    task automatic check_imem();
        int idx, cnt;
        while (imem_rsp_q.size() > 0 && !aborted) begin
            idx = imem_rsp_q.pop_front();
            cnt = 0;
            do begin
                @(negedge clk_i);
                cnt++;
            end while (!(imem_rsp_valid_o && imem_rsp_ready_i) && cnt < wait_limit && !aborted);
            if (!(imem_rsp_valid_o && imem_rsp_ready_i)) begin
                if (!aborted) begin
                    report_timeout("instruction response");
                end
            end else if (imem_rdata_o !== st_exp[idx]) begin
                $display("[FAIL] imem read, stim line %0d: expected %h, actual %h",
                         st_line[idx], st_exp[idx], imem_rdata_o);
                errors++;
            end
        end
    endtask

    // ##################################################
    // Main sequence
    // ##################################################
    initial begin
        int i, cnt;
        ctrl_req_valid_i <= 1'b0;
        ctrl_we_i        <= 1'b0;
        ctrl_addr_i      <= '0;
        ctrl_wdata_i     <= '0;
        ctrl_be_i        <= '0;
        ctrl_rsp_ready_i <= 1'b1;
        imem_req_valid_i <= 1'b0;
        imem_addr_i      <= '0;
        imem_rsp_ready_i <= 1'b1;
        load_stim();
        cnt = 0;
        while (!arst_n_i && cnt < wait_limit) begin
            @(posedge clk_i);
            cnt++;
        end
        if (!arst_n_i) begin
            report_timeout("reset release");
        end
        @(negedge clk_i);
        if (ctrl_rsp_valid_o || imem_rsp_valid_o) begin
            $display("A response valid output is high right after reset");
            errors++;
        end
        i = 0;
        while (i < st_op.size() && !aborted) begin
            while (i < st_op.size() && st_op[i] != "S") begin
                if (st_port[i] == 0) begin
                    ctrl_req_q.push_back(i);
                    ctrl_rsp_q.push_back(i);
                end else begin
                    imem_req_q.push_back(i);
                    imem_rsp_q.push_back(i);
                end
                i++;
            end
            i++;
            fork
                drive_ctrl();
                drive_imem();
                check_ctrl();
                check_imem();
            join
            // Nothing may arrive once every expected response is in
            repeat (4) begin
                @(negedge clk_i);
                if (!aborted && (ctrl_rsp_valid_o || imem_rsp_valid_o)) begin
                    $display("An unexpected extra response appeared");
                    errors++;
                end
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0 && !aborted) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_bgpu_mem_assert.sv
// ##################################################
// Handshake properties of the port multiplexer
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module tb_bgpu_mem_assert (
    input logic                      clk_i,
    input logic                      arst_n_i,
    input logic                      p0_req_valid_i,
    input logic                      p0_req_ready_o,
    input logic                      p0_we_i,
    input bgpu_mem_pkg::line_addr_t  p0_addr_i,
    input bgpu_mem_pkg::mctrl_data_t p0_wdata_i,
    input bgpu_mem_pkg::mctrl_strb_t p0_strb_i,
    input logic                      p1_req_ready_o,
    input logic                      req_valid_o,
    input logic                      req_ready_i,
    input bgpu_mem_pkg::mem_req_t    req_o,
    input logic                      p0_rsp_valid_o,
    input logic                      p1_rsp_valid_o
);
    // A waiting request holds valid and payload
    p0_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        p0_req_valid_i && !p0_req_ready_o |=> p0_req_valid_i && $stable(p0_we_i)
        && $stable(p0_addr_i) && $stable(p0_wdata_i) && $stable(p0_strb_i))
        else $error("port 0 request changed before its transfer");

    // The merged request keeps its grant while it waits
    req_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o))
        else $error("merged request changed before its transfer");

    // Only one port is granted at a time
    one_ready_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(p0_req_ready_o && p1_req_ready_o))
        else $error("both port ready outputs high");

    reset_quiet_a : assert property (@(posedge clk_i)
        !arst_n_i |-> !(req_valid_o || p0_rsp_valid_o || p1_rsp_valid_o))
        else $error("valid output high during reset");

endmodule

bind mctrl_mux tb_bgpu_mem_assert i_mux_assert (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .p0_req_valid_i(p0_req_valid_i),
    .p0_req_ready_o(p0_req_ready_o),
    .p0_we_i       (p0_we_i),
    .p0_addr_i     (p0_addr_i),
    .p0_wdata_i    (p0_wdata_i),
    .p0_strb_i     (p0_strb_i),
    .p1_req_ready_o(p1_req_ready_o),
    .req_valid_o   (req_valid_o),
    .req_ready_i   (req_ready_i),
    .req_o         (req_o),
    .p0_rsp_valid_o(p0_rsp_valid_o),
    .p1_rsp_valid_o(p1_rsp_valid_o)
);

`default_nettype wire

// File: tb_clk_gen.sv
// ##################################################
// Free-running 4 ns clock, reset low for the first 3 cycles
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

    always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: bgpu_mem_top.sv
// ##################################################
// Request latency is 3 cycles at least, order kept per port
// Response back-pressure on one port can stall the other
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module bgpu_mem_top (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    // Control port
    input  logic                      ctrl_req_valid_i,
    output logic                      ctrl_req_ready_o,
    input  logic                      ctrl_we_i,
    input  bgpu_mem_pkg::ctrl_addr_t  ctrl_addr_i,
    input  bgpu_mem_pkg::ctrl_data_t  ctrl_wdata_i,
    input  bgpu_mem_pkg::ctrl_be_t    ctrl_be_i,
    output logic                      ctrl_rsp_valid_o,
    input  logic                      ctrl_rsp_ready_i,
    output bgpu_mem_pkg::ctrl_data_t  ctrl_rdata_o,

    // Instruction port
    input  logic                      imem_req_valid_i,
    output logic                      imem_req_ready_o,
    input  bgpu_mem_pkg::line_addr_t  imem_addr_i,
    output logic                      imem_rsp_valid_o,
    input  logic                      imem_rsp_ready_i,
    output bgpu_mem_pkg::mctrl_data_t imem_rdata_o
);
    // Control accesses widened to lines
    logic                      line_req_valid, line_req_ready, line_we;
    bgpu_mem_pkg::line_addr_t  line_addr;
    bgpu_mem_pkg::mctrl_data_t line_wdata, line_rdata;
    bgpu_mem_pkg::mctrl_strb_t line_strb;
    logic                      line_rsp_valid, line_rsp_ready;

    // Merged request and response streams
    logic                   mux_req_valid, mux_req_ready, mem_req_valid, mem_req_ready;
    bgpu_mem_pkg::mem_req_t mux_req, mem_req;
    logic                   mem_rsp_valid, mem_rsp_ready, mux_rsp_valid, mux_rsp_ready;
    bgpu_mem_pkg::mem_rsp_t mem_rsp, mux_rsp;

    ctrl_dw_conv i_ctrl_dw_conv (
        .clk_i, .arst_n_i,
        .req_valid_i     (ctrl_req_valid_i), .req_ready_o     (ctrl_req_ready_o),
        .we_i            (ctrl_we_i),        .addr_i          (ctrl_addr_i),
        .wdata_i         (ctrl_wdata_i),     .be_i            (ctrl_be_i),
        .rsp_valid_o     (ctrl_rsp_valid_o), .rsp_ready_i     (ctrl_rsp_ready_i),
        .rdata_o         (ctrl_rdata_o),
        .line_req_valid_o(line_req_valid),   .line_req_ready_i(line_req_ready),
        .line_we_o       (line_we),          .line_addr_o     (line_addr),
        .line_wdata_o    (line_wdata),       .line_strb_o     (line_strb),
        .line_rsp_valid_i(line_rsp_valid),   .line_rsp_ready_o(line_rsp_ready),
        .line_rdata_i    (line_rdata)
    );

    mctrl_mux i_mctrl_mux (
        .clk_i, .arst_n_i,
        .p0_req_valid_i(line_req_valid),   .p0_req_ready_o(line_req_ready),
        .p0_we_i       (line_we),          .p0_addr_i     (line_addr),
        .p0_wdata_i    (line_wdata),       .p0_strb_i     (line_strb),
        .p0_rsp_valid_o(line_rsp_valid),   .p0_rsp_ready_i(line_rsp_ready),
        .p0_rdata_o    (line_rdata),
        .p1_req_valid_i(imem_req_valid_i), .p1_req_ready_o(imem_req_ready_o),
        .p1_addr_i     (imem_addr_i),
        .p1_rsp_valid_o(imem_rsp_valid_o), .p1_rsp_ready_i(imem_rsp_ready_i),
        .p1_rdata_o    (imem_rdata_o),
        .req_valid_o   (mux_req_valid),    .req_ready_i   (mux_req_ready),
        .req_o         (mux_req),
        .rsp_valid_i   (mux_rsp_valid),    .rsp_ready_o   (mux_rsp_ready),
        .rsp_i         (mux_rsp)
    );

    mem_spill_reg #(.payload_t(bgpu_mem_pkg::mem_req_t)) i_req_spill (
        .clk_i, .arst_n_i,
        .valid_i(mux_req_valid), .ready_o(mux_req_ready), .data_i(mux_req),
        .valid_o(mem_req_valid), .ready_i(mem_req_ready), .data_o(mem_req)
    );

    mctrl_mem i_mctrl_mem (
        .clk_i, .arst_n_i,
        .req_valid_i(mem_req_valid), .req_ready_o(mem_req_ready), .req_i(mem_req),
        .rsp_valid_o(mem_rsp_valid), .rsp_ready_i(mem_rsp_ready), .rsp_o(mem_rsp)
    );

    mem_spill_reg #(.payload_t(bgpu_mem_pkg::mem_rsp_t)) i_rsp_spill (
        .clk_i, .arst_n_i,
        .valid_i(mem_rsp_valid), .ready_o(mem_rsp_ready), .data_i(mem_rsp),
        .valid_o(mux_rsp_valid), .ready_i(mux_rsp_ready), .data_o(mux_rsp)
    );

endmodule

`default_nettype wire

// File: mctrl_mem.sv
// ##################################################
// 64 lines of 128 bits, all zero at start of simulation
// Write responses return the line contents before the write
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module mctrl_mem (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  bgpu_mem_pkg::mem_req_t req_i,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output bgpu_mem_pkg::mem_rsp_t rsp_o
);
    bgpu_mem_pkg::mctrl_data_t mem_q [2**bgpu_mem_pkg::LineIdxWidth];
    logic                      rsp_valid_q;
    bgpu_mem_pkg::mem_rsp_t    rsp_q;
    logic                      req_fire;

    initial begin
        for (int unsigned i = 0; i < 2**bgpu_mem_pkg::LineIdxWidth; i++) begin
            mem_q[i] = '0;
        end
    end

    // Accept only while the response register can take the result
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    // Array and response payload
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            rsp_q.data <= mem_q[req_i.addr];
            rsp_q.src  <= req_i.src;
            for (int unsigned b = 0; b < bgpu_mem_pkg::MctrlStrbWidth; b++) begin
                if (req_i.we && req_i.strb[b]) begin
                    mem_q[req_i.addr][b*8 +: 8] <= req_i.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: mem_spill_reg.sv
// ##################################################
// Two slots, ready_o comes from flops only
// Slot b always holds the older item when both are full
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module mem_spill_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);
    logic     a_full_q, b_full_q;
    logic     a_fill, a_drain, b_fill, b_drain;
    payload_t a_data_q, b_data_q;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    // Slot a spills into b when the output stalls
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            if (a_fill || a_drain) begin
                a_full_q <= a_fill;
            end
            if (b_fill || b_drain) begin
                b_full_q <= b_fill;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_fill) begin
            a_data_q <= data_i;
        end
        if (b_fill) begin
            b_data_q <= a_data_q;
        end
    end

endmodule

`default_nettype wire

// File: mctrl_mux.sv
// ##################################################
// Port 0 carries control accesses, port 1 instruction reads only
// A grant is held while the merged request waits for ready
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module mctrl_mux (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    // Port 0, control
    input  logic                      p0_req_valid_i,
    output logic                      p0_req_ready_o,
    input  logic                      p0_we_i,
    input  bgpu_mem_pkg::line_addr_t  p0_addr_i,
    input  bgpu_mem_pkg::mctrl_data_t p0_wdata_i,
    input  bgpu_mem_pkg::mctrl_strb_t p0_strb_i,
    output logic                      p0_rsp_valid_o,
    input  logic                      p0_rsp_ready_i,
    output bgpu_mem_pkg::mctrl_data_t p0_rdata_o,

    // Port 1, instruction fetch
    input  logic                      p1_req_valid_i,
    output logic                      p1_req_ready_o,
    input  bgpu_mem_pkg::line_addr_t  p1_addr_i,
    output logic                      p1_rsp_valid_o,
    input  logic                      p1_rsp_ready_i,
    output bgpu_mem_pkg::mctrl_data_t p1_rdata_o,

    // Merged side
    output logic                      req_valid_o,
    input  logic                      req_ready_i,
    output bgpu_mem_pkg::mem_req_t    req_o,
    input  logic                      rsp_valid_i,
    output logic                      rsp_ready_o,
    input  bgpu_mem_pkg::mem_rsp_t    rsp_i
);
    logic [bgpu_mem_pkg::NumPorts-1:0] req_valid;
    logic [bgpu_mem_pkg::NumPorts-1:0] gnt;
    logic [bgpu_mem_pkg::NumPorts-1:0] gnt_q;
    logic                              locked_q;
    // High when port 1 was served last
    logic                              last_gnt_q;

    // ##################################################
    // Arbitration
    // ##################################################
    assign req_valid = {p1_req_valid_i, p0_req_valid_i};

    always_comb begin
        if (locked_q) begin
            gnt = gnt_q;
        end else begin
            gnt[0] = req_valid[0] && (!req_valid[1] || last_gnt_q);
            gnt[1] = req_valid[1] && (!req_valid[0] || !last_gnt_q);
        end
    end

    assign req_valid_o    = |req_valid;
    assign p0_req_ready_o = gnt[0] && req_ready_i;
    assign p1_req_ready_o = gnt[1] && req_ready_i;

    // Instruction requests become tagged reads with no strobes
    always_comb begin
        if (gnt[1]) begin
            req_o.we   = 1'b0;
            req_o.addr = p1_addr_i;
            req_o.data = '0;
            req_o.strb = '0;
            req_o.src  = bgpu_mem_pkg::SrcImem;
        end else begin
            req_o.we   = p0_we_i;
            req_o.addr = p0_addr_i;
            req_o.data = p0_wdata_i;
            req_o.strb = p0_strb_i;
            req_o.src  = bgpu_mem_pkg::SrcCtrl;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_gnt_q <= 1'b1;
            locked_q   <= 1'b0;
            gnt_q      <= '0;
        end else begin
            locked_q <= req_valid_o && !req_ready_i;
            gnt_q    <= gnt;
            if (req_valid_o && req_ready_i) begin
                last_gnt_q <= gnt[1];
            end
        end
    end

    // ##################################################
    // Response routing by source tag
    // ##################################################
    assign p0_rsp_valid_o = rsp_valid_i && (rsp_i.src == bgpu_mem_pkg::SrcCtrl);
    assign p1_rsp_valid_o = rsp_valid_i && (rsp_i.src == bgpu_mem_pkg::SrcImem);
    assign p0_rdata_o     = rsp_i.data;
    assign p1_rdata_o     = rsp_i.data;
    assign rsp_ready_o    = (rsp_i.src == bgpu_mem_pkg::SrcImem) ? p1_rsp_ready_i
                                                                 : p0_rsp_ready_i;

endmodule

`default_nettype wire

// File: ctrl_dw_conv.sv
// ##################################################
// Only one control access is in flight at a time
// Byte address bits 1..0 are ignored, accesses are word aligned
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module ctrl_dw_conv (
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    // Control side
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic                      we_i,
    input  bgpu_mem_pkg::ctrl_addr_t  addr_i,
    input  bgpu_mem_pkg::ctrl_data_t  wdata_i,
    input  bgpu_mem_pkg::ctrl_be_t    be_i,
    output logic                      rsp_valid_o,
    input  logic                      rsp_ready_i,
    output bgpu_mem_pkg::ctrl_data_t  rdata_o,

    // Line side
    output logic                      line_req_valid_o,
    input  logic                      line_req_ready_i,
    output logic                      line_we_o,
    output bgpu_mem_pkg::line_addr_t  line_addr_o,
    output bgpu_mem_pkg::mctrl_data_t line_wdata_o,
    output bgpu_mem_pkg::mctrl_strb_t line_strb_o,
    input  logic                      line_rsp_valid_i,
    output logic                      line_rsp_ready_o,
    input  bgpu_mem_pkg::mctrl_data_t line_rdata_i
);
    logic                                  busy_q;
    logic [bgpu_mem_pkg::WordSelWidth-1:0] lane;
    logic [bgpu_mem_pkg::WordSelWidth-1:0] lane_q;

    // Lane sits right above the byte offset inside a word
    assign lane = addr_i[bgpu_mem_pkg::MemAddrWidth-bgpu_mem_pkg::LineIdxWidth-1
                         -: bgpu_mem_pkg::WordSelWidth];

    // ##################################################
    // Request path
    // ##################################################
    assign line_req_valid_o = req_valid_i && !busy_q;
    assign req_ready_o      = line_req_ready_i && !busy_q;
    assign line_we_o        = we_i;
    assign line_addr_o      = addr_i[bgpu_mem_pkg::MemAddrWidth-1 -: bgpu_mem_pkg::LineIdxWidth];

    // Same word in every lane, the strobes pick the one that is written
    assign line_wdata_o = {(bgpu_mem_pkg::MctrlWidth / bgpu_mem_pkg::CtrlWidth){wdata_i}};

    always_comb begin
        for (int unsigned i = 0; i < bgpu_mem_pkg::MctrlWidth / bgpu_mem_pkg::CtrlWidth; i++) begin
            line_strb_o[i*bgpu_mem_pkg::CtrlBeWidth +: bgpu_mem_pkg::CtrlBeWidth] =
                (lane == i) ? be_i : '0;
        end
    end

    // ##################################################
    // Response path
    // ##################################################
    assign rsp_valid_o      = line_rsp_valid_i;
    assign line_rsp_ready_o = rsp_ready_i;
    assign rdata_o = line_rdata_i[lane_q*bgpu_mem_pkg::CtrlWidth +: bgpu_mem_pkg::CtrlWidth];

    // Busy from accepted request until its response leaves
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            lane_q <= '0;
        end else begin
            if (req_valid_i && req_ready_o) begin
                busy_q <= 1'b1;
                lane_q <= lane;
            end else if (line_rsp_valid_i && rsp_ready_i) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bgpu_mem_pkg.sv
// ##################################################
// Widths and payload types of the memory path
// One 128-bit memory with 64 lines, so byte addresses are 10 bits
// ##################################################
`default_nettype none

package bgpu_mem_pkg;

    // ##################################################
    // Widths
    // ##################################################
    localparam int unsigned MctrlWidth     = 128;
    localparam int unsigned MctrlStrbWidth = MctrlWidth / 8;
    localparam int unsigned CtrlWidth      = 32;
    localparam int unsigned CtrlBeWidth    = CtrlWidth / 8;
    localparam int unsigned MemAddrWidth   = 10;
    localparam int unsigned LineIdxWidth   = 6;
    localparam int unsigned WordSelWidth   = 2;

    // Request sources into the multiplexer
    localparam int unsigned NumPorts   = 2;
    localparam int unsigned SrcIdWidth = 1;
    localparam logic [SrcIdWidth-1:0] SrcCtrl = 1'b0;
    localparam logic [SrcIdWidth-1:0] SrcImem = 1'b1;

    // ##################################################
    // Types
    // ##################################################
    typedef logic [MctrlWidth-1:0]     mctrl_data_t;
    typedef logic [MctrlStrbWidth-1:0] mctrl_strb_t;
    typedef logic [CtrlWidth-1:0]      ctrl_data_t;
    typedef logic [CtrlBeWidth-1:0]    ctrl_be_t;
    typedef logic [MemAddrWidth-1:0]   ctrl_addr_t;
    typedef logic [LineIdxWidth-1:0]   line_addr_t;
    typedef logic [SrcIdWidth-1:0]     src_id_t;

    // Line request as seen by the memory
    typedef struct packed {
        logic        we;
        line_addr_t  addr;
        mctrl_data_t data;
        mctrl_strb_t strb;
        src_id_t     src;
    } mem_req_t;

    // Write responses carry stale line data
    typedef struct packed {
        mctrl_data_t data;
        src_id_t     src;
    } mem_rsp_t;

endpackage

`default_nettype wire
